//--- gat_defines.svh
/* Size, width and depth macros of the graph-attention core */
`ifndef GAT_DEFINES_SVH
`define GAT_DEFINES_SVH

// ==================================================
// Graph and feature sizes
// ==================================================
`define GAT_DATA_WIDTH      8
`define GAT_NUM_FEATURE_IN  16
`define GAT_NUM_FEATURE_OUT 4
`define GAT_MAX_NODES       8
`define GAT_TOTAL_NODES     16

// Memory depths
`define GAT_H_DEPTH         128
`define GAT_WGT_DEPTH       18

// Datapath widths
`define GAT_WH_DATA_WIDTH   20
`define GAT_FEAT_WIDTH      32
`define GAT_LEAKY_SHIFT     3

// Field widths
`define GAT_COL_W           ($clog2(`GAT_NUM_FEATURE_IN))
`define GAT_ROW_LEN_W       ($clog2(`GAT_NUM_FEATURE_IN + 1))
`define GAT_NUM_NODE_W      ($clog2(`GAT_MAX_NODES + 1))

// Address widths
// Wh address is the bank bit above the node slot
`define GAT_H_ADDR_W        ($clog2(`GAT_H_DEPTH))
`define GAT_NODE_ADDR_W     ($clog2(`GAT_TOTAL_NODES))
`define GAT_WGT_ADDR_W      ($clog2(`GAT_WGT_DEPTH))
`define GAT_WH_ADDR_W       (1 + $clog2(`GAT_MAX_NODES))
`define GAT_FEAT_ADDR_W     ($clog2(`GAT_TOTAL_NODES))

`endif

//--- gat_types_pkg.sv
/* Datapath payload types: H nonzeros, node info, weight rows,
   Wh elements, rows and entries, attention coefficients */
`include "gat_defines.svh"

package gat_types_pkg;

  // One nonzero of a sparse H row
  typedef struct packed {
    logic signed [`GAT_DATA_WIDTH-1:0] val;
    logic [`GAT_COL_W-1:0]             col;
  } h_data_t;

  // Per-node info where flag marks the source of a subgraph
  typedef struct packed {
    logic [`GAT_ROW_LEN_W-1:0]  row_len;
    logic [`GAT_NUM_NODE_W-1:0] num_node;
    logic                       flag;
  } node_info_t;

  // One W row with W[row][k] in lane k
  typedef logic [`GAT_NUM_FEATURE_OUT-1:0][`GAT_DATA_WIDTH-1:0] wgt_row_t;

  typedef logic signed [`GAT_WH_DATA_WIDTH-1:0] wh_elem_t;
  typedef wh_elem_t [`GAT_NUM_FEATURE_OUT-1:0] wh_row_t;

  // Wh row as stored in the ping-pong buffer
  typedef struct packed {
    wh_row_t                    wh;
    logic [`GAT_NUM_NODE_W-1:0] num_node;
    logic                       flag;
  } wh_entry_t;

  typedef logic signed [`GAT_FEAT_WIDTH-1:0] coef_t;

endpackage

//--- gat_ctrl_pkg.sv
/* State encodings of the controller, the SpMM engine and the DMVM unit */
package gat_ctrl_pkg;

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DRAIN,
    DONE
  } ctrl_state_t;

  typedef enum logic [2:0] {
    SP_IDLE,
    SP_FETCH,
    SP_NODE,
    SP_NNZ,
    SP_WGT,
    SP_WRITE
  } spmm_state_t;

  typedef enum logic [2:0] {
    DM_IDLE,
    DM_SRC,
    DM_ADST,
    DM_MEMBER,
    DM_WRITE
  } dmvm_state_t;

endpackage

//--- gat_bram.sv
/* Simple dual-port memory, one write port and one registered read port */
`timescale 1ns/1ps

module gat_bram
  import gat_types_pkg::*;
#(
  parameter type payload_t = coef_t,
  parameter int  DEPTH     = 16,
  localparam int AW        = $clog2(DEPTH)
) (
  input  logic          clk,
  input  logic          wr_en,
  input  logic [AW-1:0] wr_addr,
  input  payload_t      wr_data,
  input  logic [AW-1:0] rd_addr,
  output payload_t      rd_data
);

  payload_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
    // Read returns old data on a same-address write
    rd_data <= mem[rd_addr];
  end

  a_wr_in_range: assert property (@(posedge clk) wr_en |-> wr_addr < DEPTH)
    else $error("gat_bram write at %0d beyond depth %0d", wr_addr, DEPTH);

endmodule

//--- gat_controller.sv
/* Layer sequencing: load-done gating, Wh bank ownership and gat_ready */
`timescale 1ns/1ps

module gat_controller
  import gat_ctrl_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic h_data_bram_load_done,
  input  logic h_node_info_bram_load_done,
  input  logic wgt_bram_load_done,
  output logic spmm_start,
  output logic spmm_bank,
  input  logic spmm_done,
  input  logic spmm_last,
  output logic dmvm_start,
  output logic dmvm_bank,
  input  logic dmvm_done,
  output logic gat_ready
);

  ctrl_state_t state;
  logic        all_loaded;
  logic [1:0]  bank_full;
  logic        spmm_busy;
  logic        dmvm_busy;
  logic        spmm_go;
  logic        dmvm_go;

  assign all_loaded = h_data_bram_load_done & h_node_info_bram_load_done & wgt_bram_load_done;
  assign gat_ready  = (state == DONE);

  // Banks are consumed in the order they were filled
  assign dmvm_go = (state == RUN || state == DRAIN) && !dmvm_busy && bank_full[dmvm_bank];
  // Never fill a bank that is full or still being read
  assign spmm_go = (state == RUN) && !spmm_busy && !bank_full[spmm_bank] &&
                   !(dmvm_busy && dmvm_bank == spmm_bank);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= IDLE;
      bank_full  <= '0;
      spmm_busy  <= 1'b0;
      dmvm_busy  <= 1'b0;
      spmm_bank  <= 1'b0;
      dmvm_bank  <= 1'b0;
      spmm_start <= 1'b0;
      dmvm_start <= 1'b0;
    end else begin
      spmm_start <= spmm_go;
      dmvm_start <= dmvm_go;
      case (state)
        IDLE: begin
          bank_full <= '0;
          spmm_busy <= 1'b0;
          dmvm_busy <= 1'b0;
          spmm_bank <= 1'b0;
          dmvm_bank <= 1'b0;
          if (all_loaded) begin
            state <= RUN;
          end
        end
        RUN, DRAIN: begin
          if (spmm_go) begin
            spmm_busy <= 1'b1;
          end
          if (spmm_done) begin
            bank_full[spmm_bank] <= 1'b1;
            spmm_busy            <= 1'b0;
            spmm_bank            <= ~spmm_bank;
            if (spmm_last) begin
              state <= DRAIN;
            end
          end
          if (dmvm_go) begin
            dmvm_busy            <= 1'b1;
            bank_full[dmvm_bank] <= 1'b0;
          end
          if (dmvm_done) begin
            dmvm_busy <= 1'b0;
            dmvm_bank <= ~dmvm_bank;
            // Last subgraph written
            if (state == DRAIN && bank_full == 2'b00) begin
              state <= DONE;
            end
          end
        end
        DONE: begin
          if (!all_loaded) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  a_bank_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    (spmm_busy && dmvm_busy) |-> (spmm_bank != dmvm_bank))
    else $error("SpMM and DMVM own Wh bank %0d together", spmm_bank);

endmodule

//--- spmm_engine.sv
/* Sparse H times dense W engine, writes one Wh entry per node of a
   subgraph into the selected ping-pong bank */
`timescale 1ns/1ps
`include "gat_defines.svh"

module spmm_engine
  import gat_types_pkg::*;
  import gat_ctrl_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        start,
  input  logic                        bank,
  output logic [`GAT_NODE_ADDR_W-1:0] node_addr,
  input  node_info_t                  node_info,
  output logic [`GAT_H_ADDR_W-1:0]    h_addr,
  input  h_data_t                     h_data,
  output logic [`GAT_WGT_ADDR_W-1:0]  wgt_addr,
  input  wgt_row_t                    wgt_row,
  output logic                        wh_wr_en,
  output logic [`GAT_WH_ADDR_W-1:0]   wh_wr_addr,
  output wh_entry_t                   wh_wr_data,
  output logic                        done,
  output logic                        last,
  output logic [`GAT_FEAT_ADDR_W-1:0] base_node
);

  spmm_state_t                        state;
  logic [`GAT_NODE_ADDR_W-1:0]        node_ptr;
  logic [`GAT_H_ADDR_W-1:0]           h_ptr;
  logic                               wh_bank;
  logic [`GAT_NUM_NODE_W-1:0]         slot;
  logic [`GAT_NUM_NODE_W-1:0]         count;
  logic [`GAT_ROW_LEN_W-1:0]          remaining;
  logic signed [`GAT_DATA_WIDTH-1:0]  h_val;
  wh_row_t                            acc;
  logic [`GAT_NUM_NODE_W-1:0]         cur_num;
  logic                               cur_flag;
  logic                               slot_last;
  logic                               node_last;

  // Running pointers drive the read ports directly
  assign node_addr = node_ptr;
  assign h_addr    = h_ptr;
  assign wgt_addr  = {{(`GAT_WGT_ADDR_W - `GAT_COL_W){1'b0}}, h_data.col};

  assign slot_last  = (slot + 1'b1 == count);
  assign node_last  = (node_ptr == `GAT_TOTAL_NODES - 1);
  assign wh_wr_en   = (state == SP_WRITE);
  assign wh_wr_addr = {wh_bank, slot[`GAT_WH_ADDR_W-2:0]};
  assign wh_wr_data = '{wh: acc, num_node: cur_num, flag: cur_flag};
  assign done       = wh_wr_en && slot_last;
  assign last       = done && node_last;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= SP_IDLE;
      node_ptr  <= '0;
      h_ptr     <= '0;
      wh_bank   <= 1'b0;
      slot      <= '0;
      count     <= '0;
      base_node <= '0;
    end else begin
      case (state)
        SP_IDLE: begin
          if (start) begin
            wh_bank   <= bank;
            base_node <= node_ptr;
            slot      <= '0;
            state     <= SP_NODE;
          end
        end
        // Wait for the node info read
        SP_FETCH: state <= SP_NODE;
        SP_NODE: begin
          if (slot == '0) begin
            count <= node_info.num_node;
          end
          remaining <= node_info.row_len;
          cur_num   <= node_info.num_node;
          cur_flag  <= node_info.flag;
          acc       <= '0;
          state     <= (node_info.row_len == '0) ? SP_WRITE : SP_NNZ;
        end
        SP_NNZ: begin
          h_val     <= h_data.val;
          h_ptr     <= h_ptr + 1'b1;
          remaining <= remaining - 1'b1;
          state     <= SP_WGT;
        end
        // W row of this nonzero's column is valid here
        SP_WGT: begin
          for (int k = 0; k < `GAT_NUM_FEATURE_OUT; k++) begin
            acc[k] <= $signed(acc[k]) + h_val * $signed(wgt_row[k]);
          end
          state <= (remaining == '0) ? SP_WRITE : SP_NNZ;
        end
        SP_WRITE: begin
          slot     <= slot + 1'b1;
          node_ptr <= node_ptr + 1'b1;
          if (slot_last) begin
            state <= SP_IDLE;
            // Rewind for the next run
            if (node_last) begin
              node_ptr <= '0;
              h_ptr    <= '0;
            end
          end else begin
            state <= SP_FETCH;
          end
        end
        default: state <= SP_IDLE;
      endcase
    end
  end

  a_row_len: assert property (@(posedge clk) disable iff (!rst_n)
    state == SP_NODE |-> node_info.row_len <= `GAT_NUM_FEATURE_IN)
    else $error("Row length %0d too large", node_info.row_len);

  a_num_node: assert property (@(posedge clk) disable iff (!rst_n)
    (state == SP_NODE && node_info.flag) |->
      (node_info.num_node >= 1 && node_info.num_node <= `GAT_MAX_NODES))
    else $error("Subgraph size %0d out of range", node_info.num_node);

endmodule

//--- dmvm_unit.sv
/* Attention step: src and dst dot products with LeakyReLU per member */
`timescale 1ns/1ps
`include "gat_defines.svh"

module dmvm_unit
  import gat_types_pkg::*;
  import gat_ctrl_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        start,
  input  logic                        bank,
  input  logic [`GAT_FEAT_ADDR_W-1:0] base_node,
  output logic [`GAT_WGT_ADDR_W-1:0]  wgt_addr,
  input  wgt_row_t                    wgt_row,
  output logic [`GAT_WH_ADDR_W-1:0]   wh_rd_addr,
  input  wh_entry_t                   wh_entry,
  output logic                        feat_wr_en,
  output logic [`GAT_FEAT_ADDR_W-1:0] feat_wr_addr,
  output coef_t                       feat_wr_data,
  output logic                        done
);

  // a_src and a_dst follow the W rows
  localparam logic [`GAT_WGT_ADDR_W-1:0] A_SRC_ADDR = `GAT_NUM_FEATURE_IN;
  localparam logic [`GAT_WGT_ADDR_W-1:0] A_DST_ADDR = `GAT_NUM_FEATURE_IN + 1;

  dmvm_state_t                 state;
  logic                        wh_bank;
  logic [`GAT_FEAT_ADDR_W-1:0] base;
  logic [`GAT_NUM_NODE_W-1:0]  member;
  logic [`GAT_NUM_NODE_W-1:0]  count;
  wgt_row_t                    a_dst;
  coef_t                       src_score;
  coef_t                       e_sum;
  coef_t                       coef;

  function automatic coef_t dot4(input wgt_row_t a, input wh_row_t w);
    coef_t sum;
    sum = '0;
    for (int k = 0; k < `GAT_NUM_FEATURE_OUT; k++) begin
      sum = sum + $signed(a[k]) * $signed(w[k]);
    end
    return sum;
  endfunction

  assign wgt_addr   = (state == DM_IDLE) ? A_SRC_ADDR : A_DST_ADDR;
  // Source slot is addressed while waiting so it is ready on the first cycle
  assign wh_rd_addr = (state == DM_IDLE) ? {bank, {(`GAT_WH_ADDR_W-1){1'b0}}}
                                         : {wh_bank, member[`GAT_WH_ADDR_W-2:0]};

  // LeakyReLU with floor shift on negative scores
  assign e_sum = src_score + dot4(a_dst, wh_entry.wh);
  assign coef  = (e_sum < 0) ? (e_sum >>> `GAT_LEAKY_SHIFT) : e_sum;

  assign feat_wr_en = (state == DM_WRITE);
  assign done       = feat_wr_en && (member == count);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= DM_IDLE;
      wh_bank <= 1'b0;
      base    <= '0;
      member  <= '0;
      count   <= '0;
    end else begin
      case (state)
        DM_IDLE: begin
          if (start) begin
            wh_bank <= bank;
            base    <= base_node;
            member  <= '0;
            state   <= DM_SRC;
          end
        end
        // a_src and the source entry arrive together
        DM_SRC: begin
          src_score <= dot4(wgt_row, wh_entry.wh);
          count     <= wh_entry.num_node;
          state     <= DM_ADST;
        end
        DM_ADST: begin
          a_dst <= wgt_row;
          state <= DM_MEMBER;
        end
        DM_MEMBER: begin
          feat_wr_data <= coef;
          feat_wr_addr <= base + member;
          member       <= member + 1'b1;
          state        <= DM_WRITE;
        end
        DM_WRITE: state <= (member == count) ? DM_IDLE : DM_MEMBER;
        default:  state <= DM_IDLE;
      endcase
    end
  end

  // Slot 0 of a bank must hold a flagged source written by the SpMM engine
  a_source_entry: assert property (@(posedge clk) disable iff (!rst_n)
    state == DM_SRC |-> (wh_entry.flag && wh_entry.num_node != '0))
    else $error("Wh bank %0d slot 0 is not a subgraph source", wh_bank);

endmodule

//--- gat_top.sv
/* Graph-attention core, first layer: host memories, SpMM engine,
   DMVM unit, ping-pong Wh buffer, coefficient memory and controller */
`timescale 1ns/1ps
`include "gat_defines.svh"

module gat_top
  import gat_types_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        h_data_bram_load_done,
  input  logic                        h_node_info_bram_load_done,
  input  logic                        wgt_bram_load_done,
  output logic                        gat_ready,

  input  h_data_t                     h_data_bram_din,
  input  logic                        h_data_bram_ena,
  input  logic                        h_data_bram_wea,
  input  logic [`GAT_H_ADDR_W-1:0]    h_data_bram_addra,

  input  node_info_t                  h_node_info_bram_din,
  input  logic                        h_node_info_bram_ena,
  input  logic                        h_node_info_bram_wea,
  input  logic [`GAT_NODE_ADDR_W-1:0] h_node_info_bram_addra,

  input  wgt_row_t                    wgt_bram_din,
  input  logic                        wgt_bram_ena,
  input  logic                        wgt_bram_wea,
  input  logic [`GAT_WGT_ADDR_W-1:0]  wgt_bram_addra,

  input  logic [`GAT_FEAT_ADDR_W-1:0] feat_bram_addrb,
  output coef_t                       feat_bram_dout
);

  logic [`GAT_NODE_ADDR_W-1:0] node_addr;
  node_info_t                  node_info;
  logic [`GAT_H_ADDR_W-1:0]    h_addr;
  h_data_t                     h_data;
  logic [`GAT_WGT_ADDR_W-1:0]  spmm_wgt_addr;
  logic [`GAT_WGT_ADDR_W-1:0]  dmvm_wgt_addr;
  wgt_row_t                    spmm_wgt_row;
  wgt_row_t                    dmvm_wgt_row;
  logic                        wh_wr_en;
  logic [`GAT_WH_ADDR_W-1:0]   wh_wr_addr;
  logic [`GAT_WH_ADDR_W-1:0]   wh_rd_addr;
  wh_entry_t                   wh_wr_data;
  wh_entry_t                   wh_entry;
  logic                        feat_wr_en;
  logic [`GAT_FEAT_ADDR_W-1:0] feat_wr_addr;
  coef_t                       feat_wr_data;
  logic [`GAT_FEAT_ADDR_W-1:0] base_node;
  logic                        spmm_start;
  logic                        spmm_bank;
  logic                        spmm_done;
  logic                        spmm_last;
  logic                        dmvm_start;
  logic                        dmvm_bank;
  logic                        dmvm_done;

  // ==================================================
  // Host-loaded memories
  // ==================================================
  gat_bram #(.payload_t(h_data_t), .DEPTH(`GAT_H_DEPTH)) u_h_data_bram (
    .clk(clk), .wr_en(h_data_bram_ena & h_data_bram_wea), .wr_addr(h_data_bram_addra),
    .wr_data(h_data_bram_din), .rd_addr(h_addr), .rd_data(h_data)
  );

  gat_bram #(.payload_t(node_info_t), .DEPTH(`GAT_TOTAL_NODES)) u_node_info_bram (
    .clk(clk), .wr_en(h_node_info_bram_ena & h_node_info_bram_wea),
    .wr_addr(h_node_info_bram_addra), .wr_data(h_node_info_bram_din),
    .rd_addr(node_addr), .rd_data(node_info)
  );

  // Two weight copies written together give each engine a read port
  gat_bram #(.payload_t(wgt_row_t), .DEPTH(`GAT_WGT_DEPTH)) u_wgt_bram_spmm (
    .clk(clk), .wr_en(wgt_bram_ena & wgt_bram_wea), .wr_addr(wgt_bram_addra),
    .wr_data(wgt_bram_din), .rd_addr(spmm_wgt_addr), .rd_data(spmm_wgt_row)
  );

  gat_bram #(.payload_t(wgt_row_t), .DEPTH(`GAT_WGT_DEPTH)) u_wgt_bram_dmvm (
    .clk(clk), .wr_en(wgt_bram_ena & wgt_bram_wea), .wr_addr(wgt_bram_addra),
    .wr_data(wgt_bram_din), .rd_addr(dmvm_wgt_addr), .rd_data(dmvm_wgt_row)
  );

  // ==================================================
  // Ping-pong Wh buffer and coefficient memory
  // ==================================================
  gat_bram #(.payload_t(wh_entry_t), .DEPTH(2 * `GAT_MAX_NODES)) u_wh_bram (
    .clk(clk), .wr_en(wh_wr_en), .wr_addr(wh_wr_addr),
    .wr_data(wh_wr_data), .rd_addr(wh_rd_addr), .rd_data(wh_entry)
  );

  gat_bram #(.payload_t(coef_t), .DEPTH(`GAT_TOTAL_NODES)) u_feat_bram (
    .clk(clk), .wr_en(feat_wr_en), .wr_addr(feat_wr_addr),
    .wr_data(feat_wr_data), .rd_addr(feat_bram_addrb), .rd_data(feat_bram_dout)
  );

  // ==================================================
  // Engines and control
  // ==================================================
  gat_controller u_controller (
    .clk(clk), .rst_n(rst_n),
    .h_data_bram_load_done(h_data_bram_load_done),
    .h_node_info_bram_load_done(h_node_info_bram_load_done),
    .wgt_bram_load_done(wgt_bram_load_done),
    .spmm_start(spmm_start), .spmm_bank(spmm_bank),
    .spmm_done(spmm_done), .spmm_last(spmm_last),
    .dmvm_start(dmvm_start), .dmvm_bank(dmvm_bank), .dmvm_done(dmvm_done),
    .gat_ready(gat_ready)
  );

  spmm_engine u_spmm (
    .clk(clk), .rst_n(rst_n), .start(spmm_start), .bank(spmm_bank),
    .node_addr(node_addr), .node_info(node_info),
    .h_addr(h_addr), .h_data(h_data),
    .wgt_addr(spmm_wgt_addr), .wgt_row(spmm_wgt_row),
    .wh_wr_en(wh_wr_en), .wh_wr_addr(wh_wr_addr), .wh_wr_data(wh_wr_data),
    .done(spmm_done), .last(spmm_last), .base_node(base_node)
  );

  dmvm_unit u_dmvm (
    .clk(clk), .rst_n(rst_n), .start(dmvm_start), .bank(dmvm_bank),
    .base_node(base_node),
    .wgt_addr(dmvm_wgt_addr), .wgt_row(dmvm_wgt_row),
    .wh_rd_addr(wh_rd_addr), .wh_entry(wh_entry),
    .feat_wr_en(feat_wr_en), .feat_wr_addr(feat_wr_addr), .feat_wr_data(feat_wr_data),
    .done(dmvm_done)
  );

endmodule

//--- tb_gat_model.svh
/* Reference model of the first attention layer: Wh rows, attention scores
   and LeakyReLU coefficients */
`ifndef TB_GAT_MODEL_SVH
`define TB_GAT_MODEL_SVH

// ==================================================
// Expected values
// ==================================================
localparam int LEAKY_DIV = 1 << `GAT_LEAKY_SHIFT;

int wh_model [`GAT_TOTAL_NODES][`GAT_NUM_FEATURE_OUT];
int exp_coef [`GAT_TOTAL_NODES];

// Wh_i[k] summed over the nonzeros (v, c) of row i
task automatic compute_wh_rows();
  int sum;
  for (int i = 0; i < `GAT_TOTAL_NODES; i++) begin
    for (int k = 0; k < `GAT_NUM_FEATURE_OUT; k++) begin
      sum = 0;
      for (int n = 0; n < nnz_count[i]; n++) begin
        sum += nz_val[i][n] * w_mat[nz_col[i][n]][k];
      end
      wh_model[i][k] = sum;
    end
  end
endtask

// Dot product of a_src or a_dst with one Wh row
function automatic int attention_dot(input bit use_dst, input int node);
  int sum;
  sum = 0;
  for (int k = 0; k < `GAT_NUM_FEATURE_OUT; k++) begin
    sum += (use_dst ? a_dst[k] : a_src[k]) * wh_model[node][k];
  end
  return sum;
endfunction

// Negative scores are divided with rounding toward minus infinity
function automatic int leaky_relu_floor(input int e);
  if (e >= 0) begin
    return e;
  end
  return -((-e + LEAKY_DIV - 1) / LEAKY_DIV);
endfunction

task automatic compute_coefficients();
  int src;
  int e;
  src = 0;
  compute_wh_rows();
  for (int j = 0; j < `GAT_TOTAL_NODES; j++) begin
    // Source of the current run
    if (src_flag[j]) begin
      src = j;
    end
    e = attention_dot(1'b0, src) + attention_dot(1'b1, j);
    exp_coef[j] = leaky_relu_floor(e);
  end
endtask

`endif

//--- tb_gat_top.sv
/* Testbench of the graph-attention core: random graph loads, model
   comparison of all coefficients and load_done sequencing */
`timescale 1ns/1ps
`include "gat_defines.svh"

module tb_gat_top
  import gat_types_pkg::*;
();

  localparam int N           = `GAT_TOTAL_NODES;
  localparam int MAX_ROW_NNZ = `GAT_H_DEPTH / `GAT_TOTAL_NODES;
  localparam int TIMEOUT     = 5000;
  localparam int IDLE_WINDOW = 1000;
  localparam int MODE_RANDOM = 0;
  localparam int MODE_ZERO   = 1;
  localparam int MODE_NEG    = 2;
  localparam int MODE_SPLIT  = 3;

  logic                        clk;
  logic                        rst_n;
  logic                        h_data_bram_load_done;
  logic                        h_node_info_bram_load_done;
  logic                        wgt_bram_load_done;
  logic                        gat_ready;
  h_data_t                     h_data_bram_din;
  logic                        h_data_bram_ena;
  logic                        h_data_bram_wea;
  logic [`GAT_H_ADDR_W-1:0]    h_data_bram_addra;
  node_info_t                  h_node_info_bram_din;
  logic                        h_node_info_bram_ena;
  logic                        h_node_info_bram_wea;
  logic [`GAT_NODE_ADDR_W-1:0] h_node_info_bram_addra;
  wgt_row_t                    wgt_bram_din;
  logic                        wgt_bram_ena;
  logic                        wgt_bram_wea;
  logic [`GAT_WGT_ADDR_W-1:0]  wgt_bram_addra;
  logic [`GAT_FEAT_ADDR_W-1:0] feat_bram_addrb;
  coef_t                       feat_bram_dout;

  // Graph under test
  int          nnz_count [N];
  int          nz_val [N][MAX_ROW_NNZ];
  int          nz_col [N][MAX_ROW_NNZ];
  int          run_len [N];
  bit          src_flag [N];
  int          w_mat [`GAT_NUM_FEATURE_IN][`GAT_NUM_FEATURE_OUT];
  int          a_src [`GAT_NUM_FEATURE_OUT];
  int          a_dst [`GAT_NUM_FEATURE_OUT];
  logic [31:0] rng_state;

  `include "tb_gat_model.svh"

  gat_top dut0 (.*);

  always #4 clk = ~clk;

  // ==================================================
  // Random numbers and checks
  // ==================================================
  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  function automatic int pick_between(input int lo, input int hi);
    logic [31:0] r;
    r = xorshift32();
    return lo + int'(r % (hi - lo + 1));
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("ERR %s expected %0d actual %0d", name, $signed(expected), $signed(actual));
      $display("Testbench failed");
      $fatal(1, "Value mismatch in %s", name);
    end
  endtask

  task automatic wait_for_ready(input logic level, input string name);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (gat_ready !== level && cycles >= TIMEOUT) begin
        $display("Timeout in %s while waiting for gat_ready to become %0b", name, level);
        $display("Testbench failed");
        $fatal(1, "Timeout in %s", name);
      end
    end while (gat_ready !== level);
  endtask

  // ==================================================
  // Stimulus
  // ==================================================
  task automatic build_graph(input int mode);
    int node;
    int n;
    node = 0;
    while (node < N) begin
      // One 8-node run among one-node runs in split mode
      if (mode == MODE_SPLIT) n = (node == 1) ? 8 : 1;
      else n = pick_between(1, (N - node < `GAT_MAX_NODES) ? N - node : `GAT_MAX_NODES);
      for (int j = 0; j < n; j++) begin
        src_flag[node + j] = (j == 0);
        run_len[node + j]  = (j == 0) ? n : 0;
      end
      node += n;
    end
    for (int i = 0; i < N; i++) begin
      if (mode == MODE_ZERO && !src_flag[i]) nnz_count[i] = 0;
      else if (mode == MODE_RANDOM) nnz_count[i] = pick_between(0, MAX_ROW_NNZ);
      else nnz_count[i] = pick_between(1, MAX_ROW_NNZ);
      for (int n2 = 0; n2 < nnz_count[i]; n2++) begin
        nz_col[i][n2] = pick_between(0, `GAT_NUM_FEATURE_IN - 1);
        nz_val[i][n2] = (mode == MODE_NEG) ? pick_between(1, 127) : pick_between(-128, 127);
      end
    end
    // Positive Wh with negative a vectors drives every score below zero
    for (int k = 0; k < `GAT_NUM_FEATURE_OUT; k++) begin
      for (int r = 0; r < `GAT_NUM_FEATURE_IN; r++) begin
        w_mat[r][k] = (mode == MODE_NEG) ? pick_between(1, 127) : pick_between(-128, 127);
      end
      a_src[k] = (mode == MODE_NEG) ? pick_between(-128, -1) : pick_between(-128, 127);
      a_dst[k] = (mode == MODE_NEG) ? pick_between(-128, -1) : pick_between(-128, 127);
    end
  endtask

  task automatic load_memories();
    int       addr;
    wgt_row_t row;
    addr = 0;
    for (int i = 0; i < N; i++) begin
      for (int n = 0; n < nnz_count[i]; n++) begin
        @(posedge clk);
        h_data_bram_ena   <= 1'b1;
        h_data_bram_wea   <= 1'b1;
        h_data_bram_addra <= addr[`GAT_H_ADDR_W-1:0];
        h_data_bram_din   <= '{val: nz_val[i][n][`GAT_DATA_WIDTH-1:0],
                               col: nz_col[i][n][`GAT_COL_W-1:0]};
        addr++;
      end
    end
    for (int i = 0; i < N; i++) begin
      @(posedge clk);
      h_data_bram_ena        <= 1'b0;
      h_node_info_bram_ena   <= 1'b1;
      h_node_info_bram_wea   <= 1'b1;
      h_node_info_bram_addra <= i[`GAT_NODE_ADDR_W-1:0];
      h_node_info_bram_din   <= '{row_len: nnz_count[i][`GAT_ROW_LEN_W-1:0],
                                  num_node: run_len[i][`GAT_NUM_NODE_W-1:0],
                                  flag: src_flag[i]};
    end
    // W rows, then a_src and a_dst
    for (int r = 0; r < `GAT_WGT_DEPTH; r++) begin
      for (int k = 0; k < `GAT_NUM_FEATURE_OUT; k++) begin
        if (r < `GAT_NUM_FEATURE_IN) row[k] = w_mat[r][k][`GAT_DATA_WIDTH-1:0];
        else if (r == `GAT_NUM_FEATURE_IN) row[k] = a_src[k][`GAT_DATA_WIDTH-1:0];
        else row[k] = a_dst[k][`GAT_DATA_WIDTH-1:0];
      end
      @(posedge clk);
      h_node_info_bram_ena <= 1'b0;
      wgt_bram_ena         <= 1'b1;
      wgt_bram_wea         <= 1'b1;
      wgt_bram_addra       <= r[`GAT_WGT_ADDR_W-1:0];
      wgt_bram_din         <= row;
    end
    @(posedge clk);
    wgt_bram_ena <= 1'b0;
  endtask

  task automatic set_load_done(input logic h, input logic n, input logic w);
    @(posedge clk);
    h_data_bram_load_done      <= h;
    h_node_info_bram_load_done <= n;
    wgt_bram_load_done         <= w;
  endtask

  // Reads run from the last node down to node 0, one per cycle
  task automatic read_and_check(input string name);
    int node;
    for (int i = 0; i <= N; i++) begin
      node = N - 1 - i;
      @(posedge clk);
      if (i < N) begin
        feat_bram_addrb <= node[`GAT_FEAT_ADDR_W-1:0];
      end
      @(negedge clk);
      if (i > 0) begin
        check_value($sformatf("%s coef[%0d]", name, node + 1), exp_coef[node + 1],
                    feat_bram_dout);
      end
    end
  endtask

  task automatic check_idle_ready();
    @(negedge clk);
    check_value("ready_after_reset", 0, gat_ready);
    // A valid graph sits in memory while one level stays low
    build_graph(MODE_RANDOM);
    load_memories();
    for (int m = 0; m < 3; m++) begin
      set_load_done(m != 0, m != 1, m != 2);
      repeat (IDLE_WINDOW) begin
        @(negedge clk);
        check_value("ready_partial_load", 0, gat_ready);
      end
    end
    set_load_done(1'b0, 1'b0, 1'b0);
  endtask

  task automatic run_test(input string name, input int mode);
    build_graph(mode);
    compute_coefficients();
    load_memories();
    set_load_done(1'b1, 1'b1, 1'b1);
    wait_for_ready(1'b1, name);
    read_and_check(name);
    // Dropping one level returns the core to idle
    set_load_done(1'b1, 1'b0, 1'b1);
    wait_for_ready(1'b0, name);
    set_load_done(1'b0, 1'b0, 1'b0);
  endtask

  // ==================================================
  // Test sequence
  // ==================================================
  initial begin
    clk                        = 1'b0;
    rst_n                      = 1'b0;
    h_data_bram_load_done      = 1'b0;
    h_node_info_bram_load_done = 1'b0;
    wgt_bram_load_done         = 1'b0;
    h_data_bram_din            = '0;
    h_data_bram_ena            = 1'b0;
    h_data_bram_wea            = 1'b0;
    h_data_bram_addra          = '0;
    h_node_info_bram_din       = '0;
    h_node_info_bram_ena       = 1'b0;
    h_node_info_bram_wea       = 1'b0;
    h_node_info_bram_addra     = '0;
    wgt_bram_din               = '0;
    wgt_bram_ena               = 1'b0;
    wgt_bram_wea               = 1'b0;
    wgt_bram_addra             = '0;
    feat_bram_addrb            = '0;
    rng_state                  = 32'he2e906b3;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    check_idle_ready();
    run_test("random_load", MODE_RANDOM);
    run_test("zero_rows", MODE_ZERO);
    run_test("negative_scores", MODE_NEG);
    run_test("one_and_eight_node_runs", MODE_SPLIT);
    run_test("reload_without_reset", MODE_RANDOM);
    $display("Testbench passed");
    $finish;
  end

endmodule

//--- gat_accel.f
+incdir+.
gat_types_pkg.sv
gat_ctrl_pkg.sv
gat_bram.sv
gat_controller.sv
spmm_engine.sv
dmvm_unit.sv
gat_top.sv
tb_gat_top.sv
